/* Makefile */
VERILATOR  ?= verilator
TOP        ?= spm_tb
FILELIST   ?= project.f
FLAGS      ?= --timing --assert -Wno-fatal
BUILD_DIR  ?= obj_dir
PASS_MSG   := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* dv/spm_chk.sv */
`timescale 1ns/100ps
`default_nettype none

module spm_chk (
   input wire logic              clk_i,
   input wire logic              rst_n_i,
   input wire spm_pkg::apb_req_t h0_apb_i,
   input wire spm_pkg::apb_req_t h1_apb_i,
   input wire spm_pkg::apb_req_t h2_apb_i,
   input wire spm_pkg::apb_rsp_t h0_apb_o,
   input wire spm_pkg::apb_rsp_t h1_apb_o,
   input wire spm_pkg::apb_rsp_t h2_apb_o
);

   import spm_pkg::*;

   apb_req_t req [3];
   apb_rsp_t rsp [3];

   assign req[0] = h0_apb_i;
   assign req[1] = h1_apb_i;
   assign req[2] = h2_apb_i;
   assign rsp[0] = h0_apb_o;
   assign rsp[1] = h1_apb_o;
   assign rsp[2] = h2_apb_o;

   for (genvar g = 0; g < 3; g++) begin : g_host
      logic [1:0] acc_q;   // access cycles already spent waiting

      always_ff @(posedge clk_i) begin
         if (!rst_n_i) begin
            acc_q <= 2'd0;
         end else if (req[g].psel && req[g].penable && !rsp[g].pready) begin
            if (acc_q != 2'd3) acc_q <= acc_q + 2'd1;  // saturate
         end else begin
            acc_q <= 2'd0;
         end
      end

      ready_in_access_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         rsp[g].pready |-> req[g].psel && req[g].penable)
         else $error("host %0d pready outside access phase", g);

      err_with_ready_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         rsp[g].pslverr |-> rsp[g].pready)
         else $error("host %0d pslverr without pready", g);

      // third access cycle at the latest
      latency_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         req[g].psel && req[g].penable |-> acc_q < 2'd3)
         else $error("host %0d access longer than 3 cycles", g);

      stable_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         req[g].psel && !rsp[g].pready
         |=> $stable(req[g].paddr) && $stable(req[g].pwrite) && $stable(req[g].pwdata))
         else $error("host %0d request changed before pready", g);
   end

endmodule

`default_nettype wire

/* dv/spm_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spm_defines.svh"

module spm_tb;

   import spm_pkg::*;

   localparam int N_TESTS = 6;
   localparam int N_TXN   = 128;   // most transfers one test issues
   localparam int T_CLK   = 20;
   localparam int RST_CYC = 10;

   logic     clk_i = 1'b0;
   logic     rst_n_i;
   logic     rst_seen = 1'b0;      // first reset edge done
   apb_req_t h0_req;
   apb_req_t h1_req;
   apb_req_t h2_req;
   apb_rsp_t h0_rsp;
   apb_rsp_t h1_rsp;
   apb_rsp_t h2_rsp;
   apb_req_t req [3];              // indexed views for the checks
   apb_rsp_t rsp [3];
   int       err_cnt = 0;

   logic [`SPM_DW-1:0] shadow [2**`SPM_AW];  // reference copy of the array
   logic               known  [2**`SPM_AW];  // word written since reset
   logic [`SPM_DW-1:0] exp_rd    [3];
   logic               exp_known [3];
   logic               wr_done   [3];         // legal write completing now
   logic               last_a_q;              // last port A completer, 1 = host 1
   logic               last_a;

   spm_top dut_i (
      .clk_i    (clk_i),
      .rst_n_i  (rst_n_i),
      .h0_apb_i (h0_req),
      .h1_apb_i (h1_req),
      .h2_apb_i (h2_req),
      .h0_apb_o (h0_rsp),
      .h1_apb_o (h1_rsp),
      .h2_apb_o (h2_rsp)
   );

   bind spm_top spm_chk chk_i (.*);

   always #(T_CLK/2) clk_i = ~clk_i;

   always @(posedge clk_i) rst_seen <= 1'b1;

   assign req[0] = h0_req;
   assign req[1] = h1_req;
   assign req[2] = h2_req;
   assign rsp[0] = h0_rsp;
   assign rsp[1] = h1_rsp;
   assign rsp[2] = h2_rsp;

   // aligned and inside 2**SPM_AW words
   function automatic logic addr_legal(input logic [31:0] a);
      return (a[1:0] == 2'b00) && (a[31:`SPM_AW+2] == '0);
   endfunction

   function automatic logic [`SPM_AW-1:0] word_of(input logic [31:0] a);
      return a[`SPM_AW+1:2];
   endfunction

   function automatic logic [31:0] byte_addr(input logic [`SPM_AW-1:0] w);
      return 32'(w) << 2;
   endfunction

   // expected read data, same-cycle writes from other hosts included
   always_comb begin
      for (int o = 0; o < 3; o++) begin
         wr_done[o] = rsp[o].pready && !rsp[o].pslverr && req[o].pwrite;
      end
      for (int h = 0; h < 3; h++) begin
         exp_rd[h]    = shadow[word_of(req[h].paddr)];
         exp_known[h] = known[word_of(req[h].paddr)];
         for (int o = 0; o < 3; o++) begin   // host 2 applied last, port B wins
            if (o != h && wr_done[o] && word_of(req[o].paddr) == word_of(req[h].paddr)) begin
               exp_rd[h]    = req[o].pwdata;
               exp_known[h] = 1'b1;
            end
         end
      end
   end

   always @(posedge clk_i) begin
      for (int o = 0; o < 3; o++) begin
         if (wr_done[o]) shadow[word_of(req[o].paddr)] <= req[o].pwdata;
      end
   end

   always @(posedge clk_i) begin
      for (int w = 0; w < 2**`SPM_AW; w++) begin
         if (!rst_n_i) begin
            known[w] <= 1'b0;
         end else begin
            for (int o = 0; o < 3; o++) begin
               if (wr_done[o] && word_of(req[o].paddr) == w) known[w] <= 1'b1;
            end
         end
      end
   end

   // fairness tracking on port A
   assign last_a = (rsp[0].pready && !rsp[0].pslverr) ? 1'b0 :
                   (rsp[1].pready && !rsp[1].pslverr) ? 1'b1 : last_a_q;

   always @(posedge clk_i) begin
      if (!rst_n_i) last_a_q <= 1'b1;   // host 0 first
      else          last_a_q <= last_a;
   end

   task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                  input logic [31:0] act);
      $display("ERROR %0t %s expected %h actual %h", $time, sig, exp, act);
      err_cnt++;
   endtask

   task automatic report_fault(input string msg);
      $display("%0t %s", $time, msg);
      err_cnt++;
   endtask

   for (genvar g = 0; g < 3; g++) begin : g_check
      rd_data_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         rsp[g].pready && !rsp[g].pslverr && !req[g].pwrite && exp_known[g]
         |-> rsp[g].prdata == exp_rd[g])
         else report_mismatch($sformatf("h%0d_apb_o.prdata", g), $sampled(exp_rd[g]),
                              $sampled(rsp[g].prdata));
      err_rule_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         rsp[g].pready |-> rsp[g].pslverr == !addr_legal(req[g].paddr))
         else report_mismatch($sformatf("h%0d_apb_o.pslverr", g),
                              32'(!addr_legal($sampled(req[g].paddr))),
                              32'($sampled(rsp[g].pslverr)));
      err_first_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         req[g].psel && !req[g].penable && !addr_legal(req[g].paddr)
         |=> rsp[g].pready && rsp[g].pslverr)
         else report_fault($sformatf("host %0d: bad address not refused in first cycle", g));
      rst_quiet_a: assert property (@(posedge clk_i)
         !rst_n_i && rst_seen |-> !rsp[g].pready)
         else report_fault($sformatf("host %0d: pready raised during reset", g));
   end

   // both peers waiting means a contest on port A
   fair0_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req[0].psel && req[0].penable && !rsp[0].pready &&
      req[1].psel && req[1].penable && !rsp[1].pready && last_a |=> rsp[0].pready)
      else report_fault("contest on port A not won by host 0");
   fair1_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      req[0].psel && req[0].penable && !rsp[0].pready &&
      req[1].psel && req[1].penable && !rsp[1].pready && !last_a |=> rsp[1].pready)
      else report_fault("contest on port A not won by host 1");

   task automatic drive(input int h, input apb_req_t r);
      case (h)
         0:       h0_req <= r;
         1:       h1_req <= r;
         default: h2_req <= r;
      endcase
   endtask

   // one apb transfer, returns in the pready cycle
   task automatic xfer(input int h, input logic wr, input logic [31:0] addr,
                       input logic [31:0] wdata);
      apb_req_t r;
      int       n;
      r.psel    = 1'b1;
      r.penable = 1'b0;
      r.pwrite  = wr;
      r.paddr   = addr;
      r.pwdata  = wdata;
      @(posedge clk_i);
      drive(h, r);          // setup
      r.penable = 1'b1;
      @(posedge clk_i);
      drive(h, r);          // access
      n = 0;
      do begin
         @(negedge clk_i);  // stable sample point
         n++;
      end while (!rsp[h].pready && n < 8);
      if (!rsp[h].pready) report_fault($sformatf("host %0d: transfer never completed", h));
   endtask

   task automatic idle(input int h);
      @(posedge clk_i);
      drive(h, '0);
   endtask

   task automatic rand_traffic(input int h, input int n, inout integer s);
      logic [31:0] a;
      for (int i = 0; i < n; i++) begin
         a = byte_addr(`SPM_AW'($random(s) & 15));  // small window, many collisions
         if (($random(s) & 7) == 0) a = a | 32'h2;   // some refused
         xfer(h, 1'($random(s)), a, $random(s));
      end
      idle(h);
   endtask

   task automatic end_test(input int n, input string name, input int e0);
      $display("test %0d %s: %s, %0d errors", n, name, (err_cnt == e0) ? "ok" : "failed",
               err_cnt - e0);
   endtask

   initial begin
      #((N_TESTS * N_TXN * 6 + RST_CYC) * T_CLK);
      $display("watchdog: simulation did not finish in time");
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      integer             seed;
      integer             hseed [3];
      int                 e0;
      logic [`SPM_AW-1:0] words [16];
      seed    = 32'hf331;
      h0_req  = '0;
      h1_req  = '0;
      h2_req  = '0;
      rst_n_i = 1'b0;
      repeat (RST_CYC) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);

      e0 = err_cnt;   // writes then reads, each host alone
      for (int h = 0; h < 3; h++) begin
         for (int i = 0; i < 16; i++) begin
            words[i] = `SPM_AW'($random(seed));
            xfer(h, 1'b1, byte_addr(words[i]), $random(seed));
         end
         for (int i = 0; i < 16; i++) xfer(h, 1'b0, byte_addr(words[i]), '0);
         idle(h);
      end
      end_test(1, "basic access", e0);

      e0 = err_cnt;   // port B to port A and back
      for (int i = 0; i < 8; i++) xfer(2, 1'b1, byte_addr(`SPM_AW'(8'h40 + i)), $random(seed));
      idle(2);
      for (int i = 0; i < 8; i++) begin
         xfer(i % 2, 1'b0, byte_addr(`SPM_AW'(8'h40 + i)), '0);
         idle(i % 2);   // peers take turns
      end
      for (int i = 0; i < 8; i++) xfer(0, 1'b1, byte_addr(`SPM_AW'(8'h50 + i)), $random(seed));
      idle(0);
      for (int i = 0; i < 8; i++) xfer(2, 1'b0, byte_addr(`SPM_AW'(8'h50 + i)), '0);
      idle(2);
      end_test(2, "cross-port visibility", e0);

      e0 = err_cnt;   // same edge on both ram ports
      fork
         xfer(0, 1'b1, byte_addr(8'h60), 32'hcafe_0001);
         xfer(2, 1'b0, byte_addr(8'h60), '0);
      join
      fork
         xfer(0, 1'b1, byte_addr(8'h61), 32'h0000_aaaa);
         xfer(2, 1'b1, byte_addr(8'h61), 32'h2222_bbbb);
      join
      fork
         idle(0);
         idle(2);
      join
      xfer(1, 1'b0, byte_addr(8'h61), '0);
      idle(1);
      end_test(3, "same-edge collisions", e0);

      e0 = err_cnt;   // peers back to back, first contest straight after reset
      rst_n_i <= 1'b0;
      repeat (RST_CYC) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(posedge clk_i);
      fork
         begin
            for (int i = 0; i < 16; i++) xfer(0, 1'($random(seed)), byte_addr(`SPM_AW'(i)), i);
            idle(0);
         end
         begin
            for (int i = 0; i < 16; i++) xfer(1, 1'b1, byte_addr(`SPM_AW'(i + 16)), i);
            idle(1);
         end
      join
      end_test(4, "contention and fairness", e0);

      e0 = err_cnt;   // refused writes leave the word alone
      xfer(0, 1'b1, byte_addr(8'h70), 32'h1234_5678);
      xfer(0, 1'b1, byte_addr(8'h70) | 32'h1, 32'hdead_beef);
      idle(0);
      xfer(2, 1'b1, 32'h0000_05c0, 32'hdead_beef);   // out of range yet aliases word 8'h70
      idle(2);
      xfer(1, 1'b0, 32'h0000_1000, '0);
      idle(1);
      xfer(2, 1'b0, byte_addr(8'h70), '0);
      idle(2);
      xfer(0, 1'b0, byte_addr(8'h70), '0);
      idle(0);
      end_test(5, "error responses", e0);

      e0 = err_cnt;
      for (int h = 0; h < 3; h++) hseed[h] = seed + h;
      fork
         rand_traffic(0, 40, hseed[0]);
         rand_traffic(1, 40, hseed[1]);
         rand_traffic(2, 40, hseed[2]);
      join
      end_test(6, "random mixed traffic", e0);

      $display("tests run: %0d, errors: %0d", N_TESTS, err_cnt);
      if (err_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* hdl/spm_apb_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spm_defines.svh"

module spm_apb_port (
   input  wire logic                clk_i,
   input  wire logic                rst_n_i,
   input  wire spm_pkg::apb_req_t   apb_i,
   output spm_pkg::apb_rsp_t        apb_o,
   output spm_pkg::mem_req_t        mem_o,
   input  wire logic                gnt_i,   // request taken at this edge
   input  wire logic [`SPM_DW-1:0]  rdata_i  // ram read data for this port
);

   localparam int AW = `SPM_AW;

   enum logic [1:0] {
      st_idle,   // waiting for a setup phase
      st_req,    // strobe up, waiting for grant
      st_rsp     // pready this cycle
   } state_q, state_d;

   logic               setup;     // setup phase seen
   logic               adr_ok;    // aligned and inside the array
   logic               err_q;     // current transfer refused
   logic               err_d;
   logic               wre_q;     // captured request payload
   logic [AW-1:0]      adr_q;
   logic [`SPM_DW-1:0] dat_q;

   assign setup = apb_i.psel && !apb_i.penable;

   // word aligned, upper bits clear
   assign adr_ok = (apb_i.paddr[1:0] == 2'b00) && !(|apb_i.paddr[31:AW+2]);

   // next state
   always_comb begin
      state_d = state_q;
      err_d   = err_q;
      case (state_q)
         st_idle: begin
            if (setup) begin
               err_d   = !adr_ok;
               state_d = adr_ok ? st_req : st_rsp;  // bad address skips the ram
            end
         end
         st_req: begin
            if (gnt_i) state_d = st_rsp;  // ram latched address at this edge
         end
         st_rsp: begin
            state_d = st_idle;            // one cycle of pready
            err_d   = 1'b0;
         end
         default: begin
            state_d = st_idle;
            err_d   = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q <= st_idle;
         err_q   <= 1'b0;
      end else begin
         state_q <= state_d;
         err_q   <= err_d;
      end
   end

   // payload grabbed during setup, held through st_req
   always_ff @(posedge clk_i) begin
      if (state_q == st_idle && setup) begin
         wre_q <= apb_i.pwrite;
         adr_q <= apb_i.paddr[AW+1:2];  // byte to word address
         dat_q <= apb_i.pwdata;
      end
   end

   // memory side
   always_comb begin
      mem_o.stb = (state_q == st_req);
      mem_o.wre = wre_q;
      mem_o.adr = adr_q;
      mem_o.dat = dat_q;
   end

   // apb side, read data passes through from the ram
   always_comb begin
      apb_o.prdata  = rdata_i;
      apb_o.pready  = (state_q == st_rsp);
      apb_o.pslverr = (state_q == st_rsp) && err_q;
   end

endmodule

`default_nettype wire

/* hdl/spm_defines.svh */
`ifndef SPM_DEFINES_SVH
`define SPM_DEFINES_SVH

// scratchpad geometry, shared by rtl and testbench

// word address width, 2**SPM_AW words in the array
`define SPM_AW 8

// data width of one word in bits
`define SPM_DW 32

// apb byte addresses carry two extra low bits
// below the word address, always zero when legal

`endif

/* hdl/spm_dpram_wbr.sv */
`timescale 1ns/100ps
`default_nettype none

module spm_dpram_wbr #(
   parameter int AW = 8,   // words = 2**AW
   parameter int DW = 32   // bits per word
) (
   input  wire logic               clk_i,
   input  wire spm_pkg::mem_req_t  a_req_i,
   output logic [DW-1:0]           a_dat_o,
   input  wire spm_pkg::mem_req_t  b_req_i,
   output logic [DW-1:0]           b_dat_o
);

   logic [DW-1:0] mem_q [(1<<AW)-1:0];   // storage array

   logic [AW-1:0] a_adr_q;  // latched read addresses
   logic [AW-1:0] b_adr_q;

   logic          a_wr;     // effective write enables
   logic          b_wr;
   logic          a_hit_b;  // both ports on one word

   assign b_wr    = b_req_i.stb && b_req_i.wre;
   assign a_hit_b = (a_req_i.adr[AW-1:0] == b_req_i.adr[AW-1:0]);
   assign a_wr    = a_req_i.stb && a_req_i.wre && !(b_wr && a_hit_b); // port B wins

   // address latch on strobe, both ports
   always_ff @(posedge clk_i) begin
      if (a_req_i.stb) a_adr_q <= a_req_i.adr[AW-1:0];
      if (b_req_i.stb) b_adr_q <= b_req_i.adr[AW-1:0];
   end

   // array update, single clock for both ports
   always_ff @(posedge clk_i) begin
      if (a_wr) mem_q[a_req_i.adr[AW-1:0]] <= a_req_i.dat[DW-1:0];
      if (b_wr) mem_q[b_req_i.adr[AW-1:0]] <= b_req_i.dat[DW-1:0];
   end

   // read straight from the array at the latched address
   // so a write at the latching edge shows up right away
   assign a_dat_o = mem_q[a_adr_q];
   assign b_dat_o = mem_q[b_adr_q];

endmodule

`default_nettype wire

/* hdl/spm_pkg.sv */
`default_nettype none

`include "spm_defines.svh"

package spm_pkg;

   // one apb request as seen by a completer
   typedef struct packed {
      logic                psel;     // completer selected
      logic                penable;  // access phase
      logic                pwrite;   // 1 = write, 0 = read
      logic [31:0]         paddr;    // byte address
      logic [`SPM_DW-1:0]  pwdata;   // write data
   } apb_req_t;

   // completer answer
   typedef struct packed {
      logic [`SPM_DW-1:0]  prdata;   // read data, valid with pready
      logic                pready;   // transfer done this cycle
      logic                pslverr;  // address refused
   } apb_rsp_t;

   // request into one ram port
   // held stable by the source until granted
   typedef struct packed {
      logic                stb;      // strobe, access wanted
      logic                wre;      // write enable
      logic [`SPM_AW-1:0]  adr;      // word address
      logic [`SPM_DW-1:0]  dat;      // write data
   } mem_req_t;

   // the ram port itself has no handshake
   // the arbiter in front of port A supplies one

endpackage

`default_nettype wire

/* hdl/spm_rr_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

module spm_rr_arbiter (
   input  wire logic               clk_i,
   input  wire logic               rst_n_i,
   input  wire spm_pkg::mem_req_t  req0_i,   // host 0
   input  wire spm_pkg::mem_req_t  req1_i,   // host 1
   output logic                    gnt0_o,
   output logic                    gnt1_o,
   output spm_pkg::mem_req_t       mem_o     // to ram port A
);

   import spm_pkg::*;

   logic     last_q;   // 1 = host 1 had the last grant
   logic     both;     // contest this cycle
   mem_req_t sel_req;  // winning request

   assign both = req0_i.stb && req1_i.stb;

   // grant in the same cycle as the strobe
   always_comb begin
      gnt0_o = 1'b0;
      gnt1_o = 1'b0;
      if (both) begin
         // contest goes to the host not served last
         if (last_q) begin
            gnt0_o = 1'b1;
         end else begin
            gnt1_o = 1'b1;
         end
      end else if (req0_i.stb) begin
         gnt0_o = 1'b1;   // alone, no wait
      end else if (req1_i.stb) begin
         gnt1_o = 1'b1;
      end
   end

   // pointer moves only when something was granted
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         last_q <= 1'b1;  // host 0 wins the first contest
      end else if (gnt0_o) begin
         last_q <= 1'b0;
      end else if (gnt1_o) begin
         last_q <= 1'b1;
      end
   end

   // request mux
   assign sel_req = gnt1_o ? req1_i : req0_i;

   always_comb begin
      mem_o     = sel_req;
      mem_o.stb = gnt0_o || gnt1_o;   // quiet when idle
   end

endmodule

`default_nettype wire

/* hdl/spm_top.sv */
`timescale 1ns/100ps
`default_nettype none

`include "spm_defines.svh"

module spm_top (
   input  wire logic              clk_i,
   input  wire logic              rst_n_i,
   input  wire spm_pkg::apb_req_t h0_apb_i,  // peer hosts on port A
   input  wire spm_pkg::apb_req_t h1_apb_i,
   input  wire spm_pkg::apb_req_t h2_apb_i,  // owns port B
   output spm_pkg::apb_rsp_t      h0_apb_o,
   output spm_pkg::apb_rsp_t      h1_apb_o,
   output spm_pkg::apb_rsp_t      h2_apb_o
);

   import spm_pkg::*;

   mem_req_t           h0_mem;     // per-host requests
   mem_req_t           h1_mem;
   mem_req_t           h2_mem;
   mem_req_t           a_mem;      // arbitrated port A request
   logic               h0_gnt;
   logic               h1_gnt;
   logic [`SPM_DW-1:0] a_rdata;    // shared by hosts 0 and 1
   logic [`SPM_DW-1:0] b_rdata;

   spm_apb_port h0_port_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .apb_i   (h0_apb_i),
      .apb_o   (h0_apb_o),
      .mem_o   (h0_mem),
      .gnt_i   (h0_gnt),
      .rdata_i (a_rdata)
   );

   spm_apb_port h1_port_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .apb_i   (h1_apb_i),
      .apb_o   (h1_apb_o),
      .mem_o   (h1_mem),
      .gnt_i   (h1_gnt),
      .rdata_i (a_rdata)
   );

   // host 2 never waits, port B is its own
   spm_apb_port h2_port_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .apb_i   (h2_apb_i),
      .apb_o   (h2_apb_o),
      .mem_o   (h2_mem),
      .gnt_i   (1'b1),
      .rdata_i (b_rdata)
   );

   spm_rr_arbiter arb_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req0_i  (h0_mem),
      .req1_i  (h1_mem),
      .gnt0_o  (h0_gnt),
      .gnt1_o  (h1_gnt),
      .mem_o   (a_mem)
   );

   spm_dpram_wbr #(
      .AW (`SPM_AW),
      .DW (`SPM_DW)
   ) ram_i (
      .clk_i   (clk_i),
      .a_req_i (a_mem),
      .a_dat_o (a_rdata),
      .b_req_i (h2_mem),
      .b_dat_o (b_rdata)
   );

endmodule

`default_nettype wire

/* project.f */
+incdir+hdl
hdl/spm_pkg.sv
hdl/spm_dpram_wbr.sv
hdl/spm_apb_port.sv
hdl/spm_rr_arbiter.sv
hdl/spm_top.sv
dv/spm_chk.sv
dv/spm_tb.sv
